// ==== hw/spi_sdram_pkg.sv ====
package spi_sdram_pkg;

  localparam int ADDR_W      = 32;
  localparam int WORD_ADDR_W = 23;
  localparam int ROW_W       = 13;
  localparam int COL_W       = 8;
  localparam int BANK_W      = 2;
  localparam int WAIT_W      = 16;  // wide enough for the power-up wait

  // device timing in clk cycles
  localparam int T_RCD   = 2;
  localparam int T_RP    = 2;
  localparam int T_RFC   = 7;
  localparam int T_WR_AP = 4;  // write recovery plus auto precharge
  localparam int CAS_LAT = 2;

  // burst length 1, sequential, CAS latency 2, burst write
  localparam logic [ROW_W-1:0] MODE_REG = 13'b000_0_00_010_0_000;

  localparam logic [7:0] SDRAM_SPACE = 8'h00;
  localparam logic [7:0] CTRL_SPACE  = 8'hFF;

  // sdram_a source select
  localparam logic [1:0] ASEL_HOLD = 2'd0;
  localparam logic [1:0] ASEL_ROW  = 2'd1;  // also latches the request
  localparam logic [1:0] ASEL_COL  = 2'd2;
  localparam logic [1:0] ASEL_MODE = 2'd3;

  typedef enum logic [7:0] {
    SPI_WRITE = 8'h00,
    SPI_READ  = 8'h01
  } spi_cmd_e;

  // {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    CMD_LOAD_MODE = 3'b000,
    CMD_REFRESH   = 3'b001,
    CMD_PRECHARGE = 3'b010,
    CMD_ACTIVE    = 3'b011,
    CMD_WRITE     = 3'b100,
    CMD_READ      = 3'b101,
    CMD_NOP       = 3'b111
  } sdram_cmd_e;

  typedef enum logic [3:0] {
    ST_INIT_WAIT,
    ST_INIT_PRE,
    ST_INIT_REF,
    ST_INIT_MODE,
    ST_IDLE,
    ST_ACTIVATE,
    ST_RW,
    ST_READ_WAIT,
    ST_REFRESH,
    ST_DONE_WAIT
  } sdram_state_e;

endpackage

// ==== hw/spi_rw_slave.sv ====
`timescale 1ns/100ps

module spi_rw_slave
  import spi_sdram_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              csn,
  input  logic              sclk,
  input  logic              mosi,
  output logic              miso,
  output logic              rd,
  output logic              wr,
  output logic [ADDR_W-1:0] addr,
  output logic [7:0]        wr_data,
  input  logic [7:0]        rd_data
);

  logic [1:0] csn_q;
  logic [2:0] sclk_q;
  logic [1:0] mosi_q;
  logic       active;
  logic       rise;
  logic       fall;
  logic [7:0] rx;
  logic [7:0] tx;
  logic [2:0] bit_cnt;
  logic [2:0] byte_cnt;  // 0 cmd, 1..4 address, 5 and up data
  logic       byte_done;
  spi_cmd_e   cmd;

  assign active = ~csn_q[1];
  assign rise   = sclk_q[1] & ~sclk_q[2];
  assign fall   = ~sclk_q[1] & sclk_q[2];
  assign miso   = tx[7];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      csn_q     <= 2'b11;
      sclk_q    <= 3'b000;
      bit_cnt   <= 3'd0;
      byte_cnt  <= 3'd0;
      byte_done <= 1'b0;
      cmd       <= SPI_WRITE;
      addr      <= '0;
      rd        <= 1'b0;
      wr        <= 1'b0;
    end
    else
    begin
      csn_q     <= {csn_q[0], csn};
      sclk_q    <= {sclk_q[1:0], sclk};
      rd        <= 1'b0;
      wr        <= 1'b0;
      byte_done <= 1'b0;
      if (!active)
      begin
        bit_cnt  <= 3'd0;
        byte_cnt <= 3'd0;
      end
      else
      begin
        if (rise)
        begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7)
            byte_done <= 1'b1;
        end
        if (byte_done)
        begin
          if (byte_cnt != 3'd6)
            byte_cnt <= byte_cnt + 3'd1;
          if (byte_cnt == 3'd0)
            cmd <= spi_cmd_e'(rx);
          else if (byte_cnt <= 3'd4)
          begin
            addr <= {addr[ADDR_W-9:0], rx};
            rd   <= (byte_cnt == 3'd4) && (cmd == SPI_READ);  // first fetch
          end
          else if (cmd == SPI_WRITE)
            wr <= 1'b1;
          else if (cmd == SPI_READ)
          begin
            addr <= addr + 1'b1;  // prefetch the next byte
            rd   <= 1'b1;
          end
        end
        if (wr)
          addr <= addr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    mosi_q <= {mosi_q[0], mosi};
    if (rise)
      rx <= {rx[6:0], mosi_q[1]};
    if (byte_done && byte_cnt >= 3'd5)
    begin
      wr_data <= rx;
      tx      <= rd_data;  // byte fetched for the current address
    end
    else if (fall && bit_cnt != 3'd0)  // no shift right after a byte ends
      tx <= {tx[6:0], 1'b0};
    if (!active)
      tx <= 8'h00;
  end

endmodule

// ==== hw/spi_word_bridge.sv ====
`timescale 1ns/100ps

module spi_word_bridge
  import spi_sdram_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rd,
  input  logic                   wr,
  input  logic [ADDR_W-1:0]      addr,
  input  logic [7:0]             wr_data,
  output logic [7:0]             rd_data,
  output logic                   req_valid,
  output logic                   req_write,
  output logic [WORD_ADDR_W-1:0] req_addr,
  output logic [15:0]            req_wdata,
  input  logic                   req_ready,
  input  logic                   resp_valid,
  input  logic [15:0]            resp_word,
  output logic [7:0]             ctrl
);

  logic [7:0] top_byte;
  logic       in_sdram;
  logic       in_ctrl;
  logic       word_wr;
  logic [7:0] even_byte;
  logic       byte_sel;

  assign top_byte = addr[ADDR_W-1 -: 8];
  assign in_sdram = (top_byte == SDRAM_SPACE);
  assign in_ctrl  = (top_byte == CTRL_SPACE);
  assign word_wr  = wr & in_sdram & addr[0];  // odd byte completes the word

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      req_valid <= 1'b0;
      req_write <= 1'b0;
      ctrl      <= 8'h00;
    end
    else
    begin
      if (req_valid && req_ready)
        req_valid <= 1'b0;
      if (word_wr)
      begin
        req_valid <= 1'b1;
        req_write <= 1'b1;
      end
      else if (rd && in_sdram)
      begin
        req_valid <= 1'b1;
        req_write <= 1'b0;
      end
      if (wr && in_ctrl)
        ctrl <= wr_data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr && in_sdram && !addr[0])
      even_byte <= wr_data;
    if (word_wr || (rd && in_sdram))
      req_addr <= addr[WORD_ADDR_W:1];
    if (word_wr)
      req_wdata <= {even_byte, wr_data};  // big-endian packing
    if (rd)
    begin
      byte_sel <= addr[0];
      if (in_ctrl)
        rd_data <= ctrl;
      else if (!in_sdram)
        rd_data <= 8'h00;  // unmapped space
    end
    if (resp_valid)
      rd_data <= byte_sel ? resp_word[7:0] : resp_word[15:8];
  end

endmodule

// ==== hw/sdram_fsm.sv ====
`timescale 1ns/100ps

module sdram_fsm
  import spi_sdram_pkg::*;
#(
  parameter int INIT_CYCLES = 100
)
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid,
  input  logic              req_write,
  output logic              req_ready,
  output logic              resp_valid,
  output logic              init_done,
  output logic              wait_load,
  output logic [WAIT_W-1:0] wait_cycles,
  input  logic              wait_done,
  input  logic              refresh_due,
  output logic              refresh_ack,
  output sdram_cmd_e        cmd,
  output logic [1:0]        addr_sel,
  output logic              drive_dq,
  output logic              capture,
  output logic              sdram_csn,
  output logic              sdram_rasn,
  output logic              sdram_casn,
  output logic              sdram_wen
);

  sdram_state_e state;
  sdram_state_e state_next;
  sdram_cmd_e   cmd_next;
  logic         armed;       // power-up wait has been loaded
  logic         second_ref;
  logic         is_read;

  assign req_ready = (state == ST_IDLE) && !refresh_due;
  assign {sdram_rasn, sdram_casn, sdram_wen} = cmd;
  assign sdram_csn = (cmd == CMD_NOP);

  always_comb
  begin
    state_next  = state;
    cmd_next    = CMD_NOP;
    wait_load   = 1'b0;
    wait_cycles = '0;
    refresh_ack = 1'b0;
    addr_sel    = ASEL_HOLD;
    drive_dq    = 1'b0;
    capture     = 1'b0;
    case (state)
      ST_INIT_WAIT:
        if (!armed)
        begin
          wait_load   = 1'b1;
          wait_cycles = WAIT_W'(INIT_CYCLES - 2);
        end
        else if (wait_done)
        begin
          cmd_next    = CMD_PRECHARGE;
          addr_sel    = ASEL_COL;  // A10 high, all banks
          wait_load   = 1'b1;
          wait_cycles = WAIT_W'(T_RP - 1);
          state_next  = ST_INIT_PRE;
        end
      ST_INIT_PRE:
        if (wait_done)
        begin
          cmd_next    = CMD_REFRESH;
          wait_load   = 1'b1;
          wait_cycles = WAIT_W'(T_RFC - 1);
          state_next  = ST_INIT_REF;
        end
      ST_INIT_REF:
        if (wait_done)
        begin
          wait_load = 1'b1;
          if (!second_ref)
          begin
            cmd_next    = CMD_REFRESH;
            wait_cycles = WAIT_W'(T_RFC - 1);
          end
          else
          begin
            cmd_next    = CMD_LOAD_MODE;
            addr_sel    = ASEL_MODE;
            wait_cycles = WAIT_W'(2);  // mode register set time
            state_next  = ST_INIT_MODE;
          end
        end
      ST_INIT_MODE:
        if (wait_done)
          state_next = ST_IDLE;
      ST_IDLE:
        if (refresh_due)  // refresh wins over a request
        begin
          cmd_next    = CMD_REFRESH;
          refresh_ack = 1'b1;
          wait_load   = 1'b1;
          wait_cycles = WAIT_W'(T_RFC - 1);
          state_next  = ST_REFRESH;
        end
        else if (req_valid)
        begin
          cmd_next    = CMD_ACTIVE;
          addr_sel    = ASEL_ROW;
          wait_load   = 1'b1;
          wait_cycles = WAIT_W'(T_RCD - 1);
          state_next  = ST_ACTIVATE;
        end
      ST_ACTIVATE:
        if (wait_done)
        begin
          cmd_next   = is_read ? CMD_READ : CMD_WRITE;
          addr_sel   = ASEL_COL;
          drive_dq   = !is_read;
          state_next = ST_RW;
        end
      ST_RW:
      begin
        wait_load = 1'b1;
        if (is_read)
        begin
          wait_cycles = WAIT_W'(CAS_LAT - 1);
          state_next  = ST_READ_WAIT;
        end
        else
        begin
          wait_cycles = WAIT_W'(T_WR_AP - 1);
          state_next  = ST_DONE_WAIT;
        end
      end
      ST_READ_WAIT:
        if (wait_done)
        begin
          capture    = 1'b1;  // data valid on dq this cycle
          wait_load  = 1'b1;
          state_next = ST_DONE_WAIT;
        end
      ST_REFRESH, ST_DONE_WAIT:
        if (wait_done)
          state_next = ST_IDLE;
      default:
        state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state      <= ST_INIT_WAIT;
      cmd        <= CMD_NOP;
      armed      <= 1'b0;
      second_ref <= 1'b0;
      init_done  <= 1'b0;
      is_read    <= 1'b0;
      resp_valid <= 1'b0;
    end
    else
    begin
      state      <= state_next;
      cmd        <= cmd_next;
      armed      <= 1'b1;
      resp_valid <= (state == ST_DONE_WAIT) && wait_done && is_read;
      if (state == ST_INIT_REF && wait_done)
        second_ref <= 1'b1;
      if (state == ST_INIT_MODE && wait_done)
        init_done <= 1'b1;
      if (req_valid && req_ready)
        is_read <= !req_write;
    end
  end

endmodule

// ==== hw/sdram_timer.sv ====
`timescale 1ns/100ps

module sdram_timer
  import spi_sdram_pkg::*;
#(
  parameter int REFRESH_CYCLES = 390
)
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wait_load,
  input  logic [WAIT_W-1:0] wait_cycles,
  input  logic              refresh_ack,
  output logic              wait_done,
  output logic              refresh_due
);

  localparam int REF_W = $clog2(REFRESH_CYCLES);

  logic [WAIT_W-1:0] wait_cnt;
  logic [REF_W-1:0]  ref_cnt;

  assign wait_done = (wait_cnt == '0);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wait_cnt    <= '0;
      ref_cnt     <= '0;
      refresh_due <= 1'b0;
    end
    else
    begin
      if (wait_load)
        wait_cnt <= wait_cycles;
      else if (!wait_done)
        wait_cnt <= wait_cnt - 1'b1;

      // free running, independent of the wait counter
      if (refresh_ack)
        refresh_due <= 1'b0;
      if (ref_cnt == REF_W'(REFRESH_CYCLES - 1))
      begin
        ref_cnt     <= '0;
        refresh_due <= 1'b1;
      end
      else
        ref_cnt <= ref_cnt + 1'b1;
    end
  end

endmodule

// ==== hw/sdram_datapath.sv ====
`timescale 1ns/100ps

module sdram_datapath
  import spi_sdram_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [WORD_ADDR_W-1:0] req_addr,
  input  logic [15:0]            req_wdata,
  input  logic [1:0]             addr_sel,
  input  logic                   drive_dq,
  input  logic                   capture,
  output logic [ROW_W-1:0]       sdram_a,
  output logic [BANK_W-1:0]      sdram_ba,
  output logic [15:0]            sdram_dq_out,
  output logic                   sdram_dq_oe,
  output logic [1:0]             sdram_dqm,
  input  logic [15:0]            sdram_dq_in,
  output logic [15:0]            rd_word
);

  logic [COL_W-1:0] col_q;
  logic [15:0]      wdata_q;

  // request payload taken when the row is opened
  always_ff @(posedge clk)
  begin
    if (addr_sel == ASEL_ROW)
    begin
      col_q   <= req_addr[COL_W-1:0];
      wdata_q <= req_wdata;
    end
    sdram_dq_out <= wdata_q;
    if (capture)
      rd_word <= sdram_dq_in;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sdram_a     <= '0;
      sdram_ba    <= '0;
      sdram_dq_oe <= 1'b0;
      sdram_dqm   <= 2'b11;
    end
    else
    begin
      sdram_dq_oe <= drive_dq;
      sdram_dqm   <= 2'b00;  // whole words only
      case (addr_sel)
        ASEL_ROW:
        begin
          sdram_a  <= req_addr[COL_W +: ROW_W];
          sdram_ba <= req_addr[COL_W+ROW_W +: BANK_W];
        end
        ASEL_COL:
          sdram_a <= {2'b00, 1'b1, 2'b00, col_q};  // A10 gives auto precharge
        ASEL_MODE:
        begin
          sdram_a  <= MODE_REG;
          sdram_ba <= '0;
        end
        default:
          sdram_a <= sdram_a;
      endcase
    end
  end

endmodule

// ==== hw/spi_sdram_top.sv ====
`timescale 1ns/100ps

module spi_sdram_top
  import spi_sdram_pkg::*;
#(
  parameter int INIT_CYCLES    = 100,
  parameter int REFRESH_CYCLES = 390
)
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              csn,
  input  logic              sclk,
  input  logic              mosi,
  output logic              miso,
  output logic [7:0]        ctrl,
  output logic              init_done,
  output logic              sdram_csn,
  output logic              sdram_rasn,
  output logic              sdram_casn,
  output logic              sdram_wen,
  output logic [ROW_W-1:0]  sdram_a,
  output logic [BANK_W-1:0] sdram_ba,
  output logic [1:0]        sdram_dqm,
  input  logic [15:0]       sdram_dq_in,
  output logic [15:0]       sdram_dq_out,
  output logic              sdram_dq_oe
);

  logic                   rd, wr;
  logic [ADDR_W-1:0]      addr;
  logic [7:0]             wr_data, rd_data;
  logic                   req_valid, req_write, req_ready, resp_valid;
  logic [WORD_ADDR_W-1:0] req_addr;
  logic [15:0]            req_wdata, rd_word;
  logic                   wait_load, wait_done, refresh_due, refresh_ack;
  logic [WAIT_W-1:0]      wait_cycles;
  logic [1:0]             addr_sel;
  logic                   drive_dq, capture;

  spi_rw_slave spi_rw_slave_i (
    .clk, .rst_n, .csn, .sclk, .mosi, .miso,
    .rd, .wr, .addr, .wr_data, .rd_data
  );

  spi_word_bridge spi_word_bridge_i (
    .clk, .rst_n, .rd, .wr, .addr, .wr_data, .rd_data,
    .req_valid, .req_write, .req_addr, .req_wdata, .req_ready,
    .resp_valid, .resp_word(rd_word), .ctrl
  );

  sdram_fsm #(.INIT_CYCLES(INIT_CYCLES)) sdram_fsm_i (
    .clk, .rst_n, .req_valid, .req_write, .req_ready, .resp_valid, .init_done,
    .wait_load, .wait_cycles, .wait_done, .refresh_due, .refresh_ack,
    .cmd(), .addr_sel, .drive_dq, .capture,
    .sdram_csn, .sdram_rasn, .sdram_casn, .sdram_wen
  );

  sdram_timer #(.REFRESH_CYCLES(REFRESH_CYCLES)) sdram_timer_i (
    .clk, .rst_n, .wait_load, .wait_cycles, .refresh_ack,
    .wait_done, .refresh_due
  );

  sdram_datapath sdram_datapath_i (
    .clk, .rst_n, .req_addr, .req_wdata, .addr_sel, .drive_dq, .capture,
    .sdram_a, .sdram_ba, .sdram_dq_out, .sdram_dq_oe, .sdram_dqm,
    .sdram_dq_in, .rd_word
  );

endmodule

// ==== tb/sdram_model.sv ====
`timescale 1ns/100ps

module sdram_model
  import spi_sdram_pkg::*;
(
  input  logic              clk,
  input  logic              csn,
  input  logic              rasn,
  input  logic              casn,
  input  logic              wen,
  input  logic [ROW_W-1:0]  a,
  input  logic [BANK_W-1:0] ba,
  input  logic [1:0]        dqm,
  input  logic [15:0]       dq_out,
  input  logic              dq_oe,
  output logic [15:0]       dq_in,
  output int                refresh_cnt,
  output int                violations
);

  logic [15:0]      mem [logic [22:0]];  // sparse, written words only
  logic [ROW_W-1:0] open_row [4] = '{default: '0};
  int               act_time [4] = '{default: 0};
  int               cycle = 0;
  int               ref_count = 0;
  int               err_count = 0;
  logic [15:0]      dq_q = '0;
  logic [15:0]      rd_word = '0;
  logic             rd_pend = 1'b0;
  sdram_cmd_e       cmd;

  assign cmd         = sdram_cmd_e'({rasn, casn, wen});
  assign dq_in       = dq_q;
  assign refresh_cnt = ref_count;
  assign violations  = err_count;

  // unwritten words read back as a pattern of their whole address
  function automatic logic [15:0] fill_word(input logic [22:0] k);
    return k[15:0] ^ {k[22:16], k[22:14]};
  endfunction

  always @(posedge clk)
  begin
    logic [22:0] key;
    key     = {ba, open_row[ba], a[COL_W-1:0]};
    cycle   <= cycle + 1;
    rd_pend <= 1'b0;
    if (rd_pend)
      dq_q <= rd_word;  // second edge after READ
    if (!csn)
      case (cmd)
        CMD_ACTIVE:
        begin
          open_row[ba] <= a;
          act_time[ba] <= cycle;
        end
        CMD_READ, CMD_WRITE:
        begin
          if (cycle - act_time[ba] < T_RCD)
            err_count <= err_count + 1;  // tRCD broken
          if (dqm != 2'b00)
            err_count <= err_count + 1;  // masked access, whole words expected
          if (cmd == CMD_READ)
          begin
            rd_word <= mem.exists(key) ? mem[key] : fill_word(key);
            rd_pend <= 1'b1;
          end
          else if (dq_oe)
            mem[key] = dq_out;
          else
            err_count <= err_count + 1;  // write with the bus not driven
        end
        CMD_REFRESH:
          ref_count <= ref_count + 1;
        default:
          ;
      endcase
  end

endmodule

// ==== tb/tb_spi_sdram.sv ====
`timescale 1ns/100ps

module tb_spi_sdram;

  localparam int         REFRESH_CYCLES = 200;
  localparam int         NT             = 15;
  localparam int         HALF_SCLK      = 8;      // sclk period of 16 clk
  localparam logic [7:0] OP_WR          = 8'h00;
  localparam logic [7:0] OP_RD          = 8'h01;
  localparam logic [7:0] OP_IDLE        = 8'hA5;  // no frame, bus stays idle

  logic        clk = 1'b0;
  logic        rst_n;
  logic        csn;
  logic        sclk;
  logic        mosi;
  logic        miso;
  logic [7:0]  ctrl;
  logic        init_done;
  logic        sdram_csn, sdram_rasn, sdram_casn, sdram_wen, sdram_dq_oe;
  logic [12:0] sdram_a;
  logic [1:0]  sdram_ba, sdram_dqm;
  logic [15:0] sdram_dq_in, sdram_dq_out;
  int          refresh_cnt;
  int          violations;

  string       t_name [NT];
  logic [7:0]  t_op   [NT];
  logic [31:0] t_addr [NT];
  int          t_len  [NT];
  logic [7:0]  t_data [NT][8];  // write bytes or expected read bytes
  logic [7:0]  t_ctrl [NT];
  int          n_tests;

  logic [7:0]  ref_mem [logic [31:0]];  // expected SDRAM bytes by byte address
  logic [7:0]  ref_ctrl;
  logic [7:0]  ref_even;
  logic [7:0]  got [8];
  integer      seed;
  int          errors;
  int          failed;

  always #20 clk = ~clk;

  spi_sdram_top #(.INIT_CYCLES(100), .REFRESH_CYCLES(REFRESH_CYCLES)) spi_sdram_top_i (
    .clk(clk), .rst_n(rst_n), .csn(csn), .sclk(sclk), .mosi(mosi), .miso(miso),
    .ctrl(ctrl), .init_done(init_done),
    .sdram_csn(sdram_csn), .sdram_rasn(sdram_rasn), .sdram_casn(sdram_casn),
    .sdram_wen(sdram_wen), .sdram_a(sdram_a), .sdram_ba(sdram_ba), .sdram_dqm(sdram_dqm),
    .sdram_dq_in(sdram_dq_in), .sdram_dq_out(sdram_dq_out), .sdram_dq_oe(sdram_dq_oe)
  );

  sdram_model sdram_model_i (
    .clk(clk), .csn(sdram_csn), .rasn(sdram_rasn), .casn(sdram_casn), .wen(sdram_wen),
    .a(sdram_a), .ba(sdram_ba), .dqm(sdram_dqm), .dq_out(sdram_dq_out),
    .dq_oe(sdram_dq_oe), .dq_in(sdram_dq_in), .refresh_cnt(refresh_cnt),
    .violations(violations)
  );

  task automatic add_write(input string name, input logic [31:0] start, input int len);
    logic [31:0] a;
    logic [7:0]  b;
    t_name[n_tests] = name;
    t_op[n_tests]   = OP_WR;
    t_addr[n_tests] = start;
    t_len[n_tests]  = len;
    for (int i = 0; i < len; i++)
    begin
      a = start + 32'(i);
      b = 8'($random(seed));
      t_data[n_tests][i] = b;
      if (a[31:24] == 8'hFF)
        ref_ctrl = b;
      else if (a[31:24] == 8'h00 && !a[0])
        ref_even = b;
      else if (a[31:24] == 8'h00)
      begin
        ref_mem[a - 1] = ref_even;  // word lands on the odd byte
        ref_mem[a]     = b;
      end
    end
    t_ctrl[n_tests] = ref_ctrl;
    n_tests++;
  endtask

  task automatic expect_read(input string name, input logic [31:0] start, input int len);
    logic [31:0] a;
    t_name[n_tests] = name;
    t_op[n_tests]   = OP_RD;
    t_addr[n_tests] = start;
    t_len[n_tests]  = len;
    for (int i = 0; i < len; i++)
    begin
      a = start + 32'(i);
      if (a[31:24] == 8'hFF)
        t_data[n_tests][i] = ref_ctrl;
      else if (a[31:24] == 8'h00)
        t_data[n_tests][i] = ref_mem[a];
      else
        t_data[n_tests][i] = 8'h00;  // unmapped
    end
    t_ctrl[n_tests] = ref_ctrl;
    n_tests++;
  endtask

  task automatic schedule_idle(input string name);
    t_name[n_tests] = name;
    t_op[n_tests]   = OP_IDLE;
    t_addr[n_tests] = '0;
    t_len[n_tests]  = 0;
    t_ctrl[n_tests] = ref_ctrl;
    n_tests++;
  endtask

  task automatic advance(input int n);
    repeat (n) @(posedge clk);
    #5;
  endtask

  // mode 0, mosi set while sclk is low, miso taken at the rising edge
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--)
    begin
      mosi = tx[i];
      advance(HALF_SCLK);
      rx[i] = miso;
      sclk  = 1'b1;
      advance(HALF_SCLK);
      sclk  = 1'b0;
    end
  endtask

  task automatic run_frame(input int t);
    logic [7:0] dummy;
    csn = 1'b0;
    advance(HALF_SCLK);
    spi_byte(t_op[t], dummy);
    for (int k = 3; k >= 0; k--)
      spi_byte(t_addr[t][8*k +: 8], dummy);
    if (t_op[t] == OP_RD)
      spi_byte(8'h00, dummy);  // time for the first fetch
    for (int i = 0; i < t_len[t]; i++)
      if (t_op[t] == OP_WR)
        spi_byte(t_data[t][i], dummy);
      else
        spi_byte(8'h00, got[i]);
    advance(HALF_SCLK);
    csn  = 1'b1;
    mosi = 1'b0;
    advance(4 * HALF_SCLK);
  endtask

  task automatic wait_refreshes(input int t);
    int base;
    int n;
    base = refresh_cnt;
    n    = 0;
    while (refresh_cnt < base + 2 && n < 3 * REFRESH_CYCLES)
    begin
      advance(1);
      n++;
    end
    if (refresh_cnt < base + 2)
    begin
      $display("%0s: only %0d refreshes in %0d idle cycles", t_name[t], refresh_cnt - base, n);
      errors++;
    end
  endtask

  task automatic check_result(input int t);
    if (t_op[t] == OP_RD)
      for (int i = 0; i < t_len[t]; i++)
        if (got[i] !== t_data[t][i])
        begin
          $display("Mismatch %0s byte %0d: expected %02h, actual %02h",
                   t_name[t], i, t_data[t][i], got[i]);
          errors++;
        end
    if (ctrl !== t_ctrl[t])
    begin
      $display("Mismatch %0s ctrl: expected %02h, actual %02h", t_name[t], t_ctrl[t], ctrl);
      errors++;
    end
    if (errors == 0)
      $display("test %0s: ok", t_name[t]);
    else
    begin
      $display("test %0s: %0d errors", t_name[t], errors);
      failed++;
    end
  endtask

  task automatic run_tests();
    for (int t = 0; t < n_tests; t++)
    begin
      errors = 0;
      if (t_op[t] == OP_IDLE)
        wait_refreshes(t);
      else
        run_frame(t);
      check_result(t);
    end
    if (violations != 0)  // bookkeeping over the whole run
    begin
      $display("Mismatch sdram_timing: expected 0 violations, actual %0d", violations);
      $display("test sdram_timing: failed");
      failed++;
    end
    else
      $display("test sdram_timing: ok");
  endtask

  initial
  begin
    int n;
    rst_n    = 1'b0;
    csn      = 1'b1;
    sclk     = 1'b0;
    mosi     = 1'b0;
    seed     = 32'h47f8;
    n_tests  = 0;
    failed   = 0;
    ref_ctrl = 8'h00;
    ref_even = 8'h00;
    add_write("burst_wr", 32'h0000_0040, 8);
    expect_read("burst_rd", 32'h0000_0040, 8);
    add_write("word_wr", 32'h0000_0100, 2);
    expect_read("odd_rd", 32'h0000_0101, 1);
    expect_read("even_rd", 32'h0000_0100, 1);  // high half of the word
    add_write("base_wr", 32'h0000_0200, 4);
    add_write("tail_wr", 32'h0000_0200, 3);    // last byte even, never written
    expect_read("tail_rd", 32'h0000_0200, 4);
    add_write("ctrl_wr", 32'hFF00_0000, 1);
    expect_read("ctrl_rd", 32'hFF00_0000, 1);
    add_write("unmapped_wr", 32'h1200_0040, 4);
    expect_read("unmapped_rd", 32'h1200_0040, 2);
    expect_read("burst_chk", 32'h0000_0040, 8);
    schedule_idle("refresh_idle");
    expect_read("refresh_rd", 32'h0000_0040, 8);
    advance(2);
    rst_n = 1'b1;
    n = 0;
    while (!init_done && n < 1000)
    begin
      advance(1);
      n++;
    end
    if (!init_done)
    begin
      $display("init_done did not rise within %0d cycles after reset", n);
      $display("*** TEST FAILED ***");
      $finish;
    end
    else
    begin
      run_tests();
      $display("tests %0d, passed %0d, failed %0d", n_tests + 1, n_tests + 1 - failed, failed);
      if (failed == 0)
        $display("*** TEST PASSED ***");
      else
        $display("*** TEST FAILED ***");
      $finish;
    end
  end

endmodule

// ==== project.f ====
hw/spi_sdram_pkg.sv
hw/spi_rw_slave.sv
hw/spi_word_bridge.sv
hw/sdram_fsm.sv
hw/sdram_timer.sv
hw/sdram_datapath.sv
hw/spi_sdram_top.sv
tb/sdram_model.sv
tb/tb_spi_sdram.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_spi_sdram -f project.f -o tb_spi_sdram &&
  ./obj_dir/tb_spi_sdram | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null &&
  echo "run.sh: simulation passed" &&
  exit 0
echo "run.sh: build or simulation did not pass"
exit 1
